// ==== sim.f ====
ethSwitchPkg.sv
frameReceiver.sv
packetBuffer.sv
frameTransmitter.sv
ethPortTop.sv
tbEthPort_checker.sv
tbEthPort.sv

// ==== Bender.yml ====
package:
  name: eth_port

sources:
  - ethSwitchPkg.sv
  - frameReceiver.sv
  - packetBuffer.sv
  - frameTransmitter.sv
  - ethPortTop.sv
  - target: test
    files:
      - tbEthPort_checker.sv
      - tbEthPort.sv

// ==== tbEthPort.sv ====
/*
  Testbench for ethPortTop. Frames are sent one at a time and drained
  before the next, except in the gap and back-pressure tests. Random-ready
  frames stay within the buffer so the model never needs truncation there.
*/
module tbEthPort;
  timeunit 1ns;
  timeprecision 100ps;

  import ethSwitchPkg::*;

  localparam int      BufDepth       = 32;
  localparam int      IpgCycles      = 12;
  localparam macAddrT StationAddr    = 48'h0200_1234_5678;
  localparam macAddrT SourceAddr     = 48'h0200_0000_0001;
  localparam int      NumFrames      = 30;   // 1 + 1 + 4 + 20 + 2 + 2
  localparam int      MaxFrameCycles = 100;  // Preamble, 60 bytes, idle, gap
  localparam int      TimeoutNs      = NumFrames * MaxFrameCycles * 4 * 10 + 5000;

  logic    RxClk;
  logic    rstN;
  logic    RxValid;
  byteT    RxD;
  macAddrT StationMac;
  logic    RecvReady;
  logic    TxEn;
  byteT    TxD;
  logic    TxDone;
  logic    TxCrcErr;
  logic    TxTrunc;

  logic [31:0] dataLfsr  = 32'd81921;  // Frame contents
  logic [31:0] readyLfsr = 32'd81921;  // RecvReady, own state so processes don't race
  int          readyMode = 0;          // 1 = random RecvReady
  byteT        expBytes[$];            // Expected TxD stream
  logic [1:0]  expStat[$];             // {trunc, crcErr} per frame
  int          expCount[$];            // Bytes per frame
  int          bytesSeen = 0;
  int          sinceDone = 1000;       // Cycles since last TxDone

  ethPortTop #(.BufDepth(BufDepth), .IpgCycles(IpgCycles)) u_dut (
    .RxClk(RxClk), .rstN(rstN), .RxValid(RxValid), .RxD(RxD),
    .StationMac(StationMac), .RecvReady(RecvReady), .TxEn(TxEn), .TxD(TxD),
    .TxDone(TxDone), .TxCrcErr(TxCrcErr), .TxTrunc(TxTrunc)
  );

  initial begin
    RxClk = 1'b0;
    forever #5 RxClk = ~RxClk;
  end

  // Galois LFSR, one step per bit
  function automatic logic lfsrBit(inout logic [31:0] st);
    logic outBit;
    outBit = st[0];
    st = st >> 1;
    if (outBit) st = st ^ 32'h8020_0003;
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(inout logic [31:0] st, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) val = {val[30:0], lfsrBit(st)};
    return val;
  endfunction

  function automatic byteT reverseBits(byteT b);
    byteT r;
    for (int i = 0; i < 8; i++) r[i] = b[7-i];
    return r;
  endfunction

  task automatic reportError(string msg);
    $display("ERROR @%0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkByte(byteT got, byteT exp);
    if (got !== exp) reportError($sformatf("TxD 0x%02h, expected 0x%02h", got, exp));
  endtask

  task automatic checkStatus(logic gotCrc, logic gotTrunc, logic expCrc, logic expTrunc);
    if (gotCrc !== expCrc || gotTrunc !== expTrunc)
      reportError($sformatf("status crc=%b trunc=%b, expected crc=%b trunc=%b",
                            gotCrc, gotTrunc, expCrc, expTrunc));
  endtask

  task automatic driveByte(logic valid, byteT b);
    @(posedge RxClk);
    #1;
    RxValid = valid;
    RxD     = b;
  endtask

  // Build, model and send one frame; keepLen > 0 means only that many bytes fit
  task automatic sendFrame(macAddrT dest, int payLen, bit corrupt, bit delivered, int keepLen);
    byteT body[$];
    crcT  crc;
    crcT  fcsVal;
    int   idx;
    int   nOut;
    for (int i = 0; i < 6; i++) body.push_back(dest[47-8*i -: 8]);
    for (int i = 0; i < 6; i++) body.push_back(SourceAddr[47-8*i -: 8]);
    for (int i = 0; i < payLen; i++) body.push_back(byteT'(randBits(dataLfsr, 8)));
    crc = '1;
    foreach (body[i]) crc = crcStep(crc, body[i]);
    fcsVal = ~crc;
    for (int k = 0; k < 4; k++) body.push_back(reverseBits(fcsVal[31-8*k -: 8]));
    crc = '1;
    foreach (body[i]) crc = crcStep(crc, body[i]);
    if (crc != CrcResidue) reportError("frame builder produced a bad FCS");
    if (corrupt) begin
      idx = body.size() - 1 - int'(randBits(dataLfsr, 2));   // One FCS byte
      body[idx] = body[idx] ^ (byteT'(randBits(dataLfsr, 8)) | 8'h01);
    end
    if (delivered) begin
      nOut = (keepLen > 0) ? keepLen : body.size();
      for (int i = 0; i < nOut; i++) expBytes.push_back(body[i]);
      expStat.push_back({keepLen > 0, corrupt});
      expCount.push_back(nOut);
    end
    repeat (7) driveByte(1'b1, 8'h55);
    driveByte(1'b1, SfdByte);
    foreach (body[i]) driveByte(1'b1, body[i]);
    repeat (12) driveByte(1'b0, 8'h00);   // Idle gap on the input
  endtask

  task automatic waitDrained();
    wait (expCount.size() == 0);
    repeat (2) @(posedge RxClk);
  endtask

  function automatic macAddrT otherAddr();
    logic [31:0] hiBits;
    logic [31:0] loBits;
    macAddrT     a;
    hiBits = randBits(dataLfsr, 16);
    loBits = randBits(dataLfsr, 32);
    a = {hiBits[15:0], loBits};
    if (a == StationAddr || a == BroadcastMac) a[0] = ~a[0];
    return a;
  endfunction

  // RecvReady driver
  initial begin
    forever begin
      @(posedge RxClk);
      #1;
      if (readyMode == 1) RecvReady = lfsrBit(readyLfsr);
    end
  end

  // Output monitor, sampled mid-cycle
  always @(negedge RxClk) begin
    if (rstN) begin
      sinceDone++;
      if (TxEn) begin
        if (sinceDone <= IpgCycles)
          reportError($sformatf("TxEn %0d cycles after TxDone", sinceDone));
        if (expBytes.size() == 0) reportError("TxEn with no frame expected");
        checkByte(TxD, expBytes.pop_front());
        bytesSeen++;
      end
      if (TxDone) begin
        if (expCount.size() == 0) reportError("TxDone with no frame expected");
        if (bytesSeen != expCount[0])
          reportError($sformatf("frame had %0d bytes, expected %0d", bytesSeen, expCount[0]));
        checkStatus(TxCrcErr, TxTrunc, expStat[0][0], expStat[0][1]);
        void'(expCount.pop_front());
        void'(expStat.pop_front());
        bytesSeen = 0;
        sinceDone = 0;
      end else begin
        checkStatus(TxCrcErr, TxTrunc, 1'b0, 1'b0);   // Flags only with TxDone
      end
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int     payLen;
    int     pick;
    rstN       = 1'b0;
    RxValid    = 1'b0;
    RxD        = '0;
    RecvReady  = 1'b1;
    StationMac = StationAddr;
    repeat (5) @(posedge RxClk);
    #1 rstN = 1'b1;
    repeat (3) @(posedge RxClk);

    sendFrame(StationAddr, 10 + int'(randBits(dataLfsr, 5)) % 31, 1'b0, 1'b1, 0);
    waitDrained();
    sendFrame(StationAddr, 10 + int'(randBits(dataLfsr, 5)) % 31, 1'b1, 1'b1, 0);
    waitDrained();
    for (int i = 0; i < 2; i++) begin         // Foreign drops, broadcast passes
      sendFrame(otherAddr(), 10 + int'(randBits(dataLfsr, 5)) % 31, 1'b0, 1'b0, 0);
      sendFrame(BroadcastMac, 10 + int'(randBits(dataLfsr, 5)) % 31, 1'b0, 1'b1, 0);
      waitDrained();
    end

    readyMode = 1;                            // Random stream under random ready
    for (int i = 0; i < 20; i++) begin
      payLen = 10 + int'(randBits(dataLfsr, 3)) % 6;  // At most 31 bytes, fits buffer
      pick   = int'(randBits(dataLfsr, 2));
      if (pick == 0) sendFrame(otherAddr(), payLen, 1'b0, 1'b0, 0);
      else if (pick == 1) sendFrame(BroadcastMac, payLen, randBits(dataLfsr, 2) == 0, 1'b1, 0);
      else sendFrame(StationAddr, payLen, randBits(dataLfsr, 2) == 0, 1'b1, 0);
      waitDrained();
    end

    readyMode = 0;                            // Gap: second frame queued behind the first
    @(posedge RxClk);
    #1 RecvReady = 1'b0;
    sendFrame(StationAddr, 10, 1'b0, 1'b1, 0);
    @(posedge RxClk);
    #1 RecvReady = 1'b1;                      // First drains while the second arrives
    sendFrame(StationAddr, 10, 1'b0, 1'b1, 0);
    waitDrained();

    @(posedge RxClk);                         // Back-pressure: truncate, then drop
    #1 RecvReady = 1'b0;
    sendFrame(StationAddr, 44, 1'b0, 1'b1, BufDepth - 1);
    sendFrame(StationAddr, 20, 1'b0, 1'b0, 0);
    repeat (5) @(posedge RxClk);
    #1 RecvReady = 1'b1;
    waitDrained();
    repeat (60) @(posedge RxClk);             // Second frame must not show up

    if (expCount.size() == 0 && expBytes.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("Frames were left undelivered at the end of the run");
      $display("sim failed");
      $fatal(1, "undelivered frames");
    end
  end

endmodule

// ==== tbEthPort_checker.sv ====
/*
  Assertions on the receiver's credit counter, bound into frameReceiver.
*/
module tbEthPort_checker #(
  parameter int BufDepth = 32
) (
  input logic                            RxClk,
  input logic                            rstN,
  input logic [$clog2(BufDepth+1)-1:0]   credits,
  input logic                            wrEn,
  input ethSwitchPkg::entryKindT         wrKind
);
  timeunit 1ns;
  timeprecision 100ps;

  import ethSwitchPkg::*;

  // Credits can never exceed the buffer size
  creditCeiling: assert property (@(posedge RxClk) disable iff (!rstN)
    credits <= BufDepth)
    else $error("credit count above BufDepth");

  // One credit stays reserved for the end entry
  dataNeedsTwo: assert property (@(posedge RxClk) disable iff (!rstN)
    (wrEn && wrKind == entryData) |-> credits >= 2)
    else $error("data entry written with fewer than two credits");

  // End entry still has its reserved slot
  endNeedsOne: assert property (@(posedge RxClk) disable iff (!rstN)
    (wrEn && wrKind == entryEnd) |-> credits >= 1)
    else $error("end entry written without a credit");

endmodule

bind frameReceiver tbEthPort_checker #(.BufDepth(BufDepth)) u_chk (
  .RxClk(RxClk),
  .rstN(rstN),
  .credits(credits),
  .wrEn(wrEn),
  .wrKind(wrKind)
);

// ==== ethPortTop.sv ====
/*
  One receive-to-transmit port pair, all in the RxClk domain.
  Receiver to buffer uses credits; buffer to transmitter is a plain pop.
  RxD-to-TxD latency varies with RecvReady and the gap.
*/
module ethPortTop #(
  parameter int BufDepth  = 32,   // Buffer entries, also the receiver's credits
  parameter int IpgCycles = 12    // Interpacket gap in cycles
) (
  input  logic                  RxClk,
  input  logic                  rstN,
  input  logic                  RxValid,
  input  ethSwitchPkg::byteT    RxD,
  input  ethSwitchPkg::macAddrT StationMac,
  input  logic                  RecvReady,
  output logic                  TxEn,
  output ethSwitchPkg::byteT    TxD,
  output logic                  TxDone,
  output logic                  TxCrcErr,
  output logic                  TxTrunc
);
  import ethSwitchPkg::*;

  // Receiver to buffer
  logic      wrEn;
  entryKindT wrKind;
  byteT      wrByte;
  logic      creditRet;

  // Buffer to transmitter
  logic      notEmpty;
  entryKindT rdKind;
  byteT      rdByte;
  logic      rdEn;

  frameReceiver #(.BufDepth(BufDepth)) u_rx (
    .RxClk(RxClk), .rstN(rstN), .RxValid(RxValid), .RxD(RxD),
    .StationMac(StationMac), .creditRet(creditRet),
    .wrEn(wrEn), .wrKind(wrKind), .wrByte(wrByte)
  );

  packetBuffer #(.BufDepth(BufDepth)) u_buf (
    .RxClk(RxClk), .rstN(rstN), .wrEn(wrEn), .wrKind(wrKind), .wrByte(wrByte),
    .rdEn(rdEn), .notEmpty(notEmpty), .rdKind(rdKind), .rdByte(rdByte),
    .creditRet(creditRet)
  );

  frameTransmitter #(.IpgCycles(IpgCycles)) u_tx (
    .RxClk(RxClk), .rstN(rstN), .RecvReady(RecvReady), .notEmpty(notEmpty),
    .rdKind(rdKind), .rdByte(rdByte), .rdEn(rdEn), .TxEn(TxEn), .TxD(TxD),
    .TxDone(TxDone), .TxCrcErr(TxCrcErr), .TxTrunc(TxTrunc)
  );

endmodule

// ==== frameTransmitter.sv ====
/*
  Drains the buffer while RecvReady is high. Outputs are registered, one
  cycle after the pop. After TxDone no entry is popped for IpgCycles cycles,
  and none during the TxDone cycle itself.
*/
module frameTransmitter #(
  parameter int IpgCycles = 12
) (
  input  logic                    RxClk,
  input  logic                    rstN,
  input  logic                    RecvReady,
  input  logic                    notEmpty,
  input  ethSwitchPkg::entryKindT rdKind,
  input  ethSwitchPkg::byteT      rdByte,
  output logic                    rdEn,
  output logic                    TxEn,
  output ethSwitchPkg::byteT      TxD,
  output logic                    TxDone,
  output logic                    TxCrcErr,
  output logic                    TxTrunc
);
  import ethSwitchPkg::*;

  localparam int GapW = $clog2(IpgCycles + 1);

  logic [GapW-1:0] gapCnt;   // Interpacket gap, counts down to zero
  logic            popData;
  logic            popEnd;

  // Pop only with data ready, client ready and gap elapsed
  assign rdEn    = RecvReady & notEmpty & ~TxDone & (gapCnt == '0);
  assign popData = rdEn & (rdKind == entryData);
  assign popEnd  = rdEn & (rdKind == entryEnd);

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      TxEn     <= 1'b0;
      TxDone   <= 1'b0;
      TxCrcErr <= 1'b0;
      TxTrunc  <= 1'b0;
      gapCnt   <= '0;
    end else begin
      TxEn     <= popData;
      TxDone   <= popEnd;
      TxCrcErr <= popEnd & rdByte[statusCrcBit];    // Status flags only valid with TxDone
      TxTrunc  <= popEnd & rdByte[statusTruncBit];
      if (TxDone) begin
        gapCnt <= GapW'(IpgCycles);                 // Gap starts after the TxDone cycle
      end else if (gapCnt != '0) begin
        gapCnt <= gapCnt - 1'b1;
      end
    end
  end

  // Data byte register, held between frames
  always_ff @(posedge RxClk) begin
    if (popData) TxD <= rdByte;
  end

endmodule

// ==== packetBuffer.sv ====
/*
  Circular store of tagged bytes. No full flag: the receiver's credits keep
  it from writing past BufDepth entries. BufDepth must be at least 2.
  Head entry is shown combinationally; rdEn pops it at the next edge.
*/
module packetBuffer #(
  parameter int BufDepth = 32
) (
  input  logic                    RxClk,
  input  logic                    rstN,
  input  logic                    wrEn,
  input  ethSwitchPkg::entryKindT wrKind,
  input  ethSwitchPkg::byteT      wrByte,
  input  logic                    rdEn,
  output logic                    notEmpty,
  output ethSwitchPkg::entryKindT rdKind,
  output ethSwitchPkg::byteT      rdByte,
  output logic                    creditRet
);
  import ethSwitchPkg::*;

  localparam int PtrW  = $clog2(BufDepth);
  localparam int FillW = $clog2(BufDepth + 1);

  entryKindT       kindMem [BufDepth];
  byteT            byteMem [BufDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [FillW-1:0] fill;           // Entries held

  // Wrap for depths that are not a power of two
  function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(BufDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign notEmpty = (fill != '0);
  assign rdKind   = kindMem[rdPtr];
  assign rdByte   = byteMem[rdPtr];

  always_ff @(posedge RxClk) begin
    if (wrEn) begin
      kindMem[wrPtr] <= wrKind;
      byteMem[wrPtr] <= wrByte;
    end
  end

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fill      <= '0;
      creditRet <= 1'b0;
    end else begin
      if (wrEn) wrPtr <= nextPtr(wrPtr);
      if (rdEn) rdPtr <= nextPtr(rdPtr);
      fill      <= fill + FillW'(wrEn) - FillW'(rdEn);
      creditRet <= rdEn;              // Slot is free before the credit comes back
    end
  end

endmodule

// ==== frameReceiver.sv ====
/*
  Receive side. Preamble bytes before the delimiter are ignored unchecked.
  RxValid must stay high for the whole frame and drop for at least
  DestLen+1 cycles before the next delimiter, or the next frame is missed.
  Written bytes trail RxD by DestLen cycles; the end entry follows the last one.
*/
module frameReceiver #(
  parameter int BufDepth = 32
) (
  input  logic                    RxClk,
  input  logic                    rstN,
  input  logic                    RxValid,
  input  ethSwitchPkg::byteT      RxD,
  input  ethSwitchPkg::macAddrT   StationMac,
  input  logic                    creditRet,
  output logic                    wrEn,
  output ethSwitchPkg::entryKindT wrKind,
  output ethSwitchPkg::byteT      wrByte
);
  import ethSwitchPkg::*;

  localparam int CreditW = $clog2(BufDepth + 1);
  localparam int CntW    = $clog2(DestLen);

  rxStateT              rxState;
  logic                 rxLive;              // Between delimiter and RxValid low
  byteT                 dlyByte [DestLen];   // [0] newest
  logic [DestLen-1:0]   dlyValid;
  logic [CntW-1:0]      destCnt;
  crcT                  crc;
  logic                 truncated;           // Sticky for the current frame
  logic [CreditW-1:0]   credits;

  logic                 inByte;
  logic                 tailValid;
  byteT                 tailByte;
  macAddrT              destAddr;
  logic                 addrMatch;
  logic                 hasRoom;
  logic                 dataWr;
  logic                 endWr;
  byteT                 statusByte;

  assign inByte    = rxLive & RxValid;     // A frame byte after the delimiter
  assign tailValid = dlyValid[DestLen-1];
  assign tailByte  = dlyByte[DestLen-1];

  // Sixth destination byte is still on RxD at decision time
  assign destAddr  = {dlyByte[4], dlyByte[3], dlyByte[2], dlyByte[1], dlyByte[0], RxD};
  assign addrMatch = (destAddr == StationMac) || (destAddr == BroadcastMac);
  assign hasRoom   = credits >= CreditW'(2);  // One credit kept for the end entry

  // Delayed stream is contiguous, so its first low cycle closes the frame
  assign dataWr = (rxState == rxForward) & tailValid & ~truncated & hasRoom;
  assign endWr  = (rxState == rxForward) & ~tailValid;

  always_comb begin
    statusByte                 = '0;
    statusByte[statusCrcBit]   = (crc != CrcResidue);
    statusByte[statusTruncBit] = truncated;
  end

  assign wrEn   = dataWr | endWr;
  assign wrKind = endWr ? entryEnd : entryData;
  assign wrByte = endWr ? statusByte : tailByte;

  // Control state
  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      rxState   <= rxIdle;
      rxLive    <= 1'b0;
      destCnt   <= '0;
      truncated <= 1'b0;
      credits   <= CreditW'(BufDepth);
      dlyValid  <= '0;
    end else begin
      credits  <= credits - CreditW'(wrEn) + CreditW'(creditRet);
      dlyValid <= {dlyValid[DestLen-2:0], inByte};
      if (!RxValid) rxLive <= 1'b0;   // Frame over on the input side

      case (rxState)
        rxIdle: begin
          if (RxValid && RxD == SfdByte) begin
            rxState   <= rxDestHold;
            rxLive    <= 1'b1;
            destCnt   <= '0;
            truncated <= 1'b0;
          end
        end
        rxDestHold: begin
          if (!RxValid) begin
            rxState <= rxIdle;              // Runt, nothing written
          end else if (destCnt == CntW'(DestLen - 1)) begin
            rxState <= (addrMatch && hasRoom) ? rxForward : rxDiscard;
          end else begin
            destCnt <= destCnt + 1'b1;
          end
        end
        rxForward: begin
          if (tailValid && !hasRoom) truncated <= 1'b1;  // Out of room, drop the rest
          if (endWr) rxState <= rxIdle;
        end
        rxDiscard: begin
          if (!RxValid) rxState <= rxIdle;
        end
        default: rxState <= rxIdle;
      endcase
    end
  end

  // Delay line and running CRC
  always_ff @(posedge RxClk) begin
    dlyByte[0] <= RxD;
    for (int i = 1; i < DestLen; i++) begin
      dlyByte[i] <= dlyByte[i-1];
    end
    if (rxState == rxIdle) begin
      crc <= '1;                        // Seed, delimiter not included
    end else if (inByte) begin
      crc <= crcStep(crc, RxD);         // Covers dest through FCS
    end
  end

endmodule

// ==== ethSwitchPkg.sv ====
/*
  Shared types and constants for the single-port switch path.
  CRC-32 is kept MSB-first with each byte fed LSB first, so a good frame
  with its FCS leaves CrcResidue in the register.
*/
package ethSwitchPkg;

  typedef logic [7:0]  byteT;     // One frame byte
  typedef logic [47:0] macAddrT;  // MAC address, first byte on the wire in [47:40]
  typedef logic [31:0] crcT;      // CRC-32 state

  // Kind of a buffer entry
  typedef enum logic {
    entryData,  // Frame byte
    entryEnd    // Status byte closing a frame
  } entryKindT;

  // Receiver FSM
  typedef enum logic [1:0] {
    rxIdle,      // Hunting for the delimiter
    rxDestHold,  // Collecting destination address
    rxForward,   // Frame accepted, bytes go to the buffer
    rxDiscard    // Frame dropped, wait for RxValid low
  } rxStateT;

  // Flag positions inside an end entry's byte
  localparam int statusCrcBit   = 0;
  localparam int statusTruncBit = 1;

  localparam byteT    SfdByte      = 8'hD5;
  localparam macAddrT BroadcastMac = 48'hFFFF_FFFF_FFFF;
  localparam crcT     CrcResidue   = 32'hC704_DD7B;  // Good frame incl. FCS
  localparam crcT     CrcPoly      = 32'h04C1_1DB7;  // IEEE 802.3 polynomial
  localparam int      DestLen      = 6;              // Destination bytes held back

  // One byte through the CRC, bit 0 of the byte first
  function automatic crcT crcStep(crcT crc, byteT data);
    crcT nextCrc;
    logic feedback;
    nextCrc = crc;
    for (int i = 0; i < 8; i++) begin
      feedback = nextCrc[31] ^ data[i];
      nextCrc  = {nextCrc[30:0], 1'b0};
      if (feedback) begin
        nextCrc = nextCrc ^ CrcPoly;
      end
    end
    return nextCrc;
  endfunction

endpackage
